// ==== ccu.f ====
rtl/ccu_pkg.sv
rtl/ccu_axil_regs.sv
rtl/ccu_result_tracker.sv
rtl/ccu_fsm.sv
rtl/ccu_top.sv
test/ccu_assertions.sv
test/tb_ccu.sv

// ==== test/tb_ccu.sv ====
module tb_ccu
  import ccu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 500;

  logic                       fsm_clk;
  logic                       fsm_rst;
  axil_addr_t                 s_axil_awaddr;
  logic                       s_axil_awvalid;
  logic                       s_axil_awready;
  axil_data_t                 s_axil_wdata;
  logic                       s_axil_wvalid;
  logic                       s_axil_wready;
  logic [1:0]                 s_axil_bresp;
  logic                       s_axil_bvalid;
  logic                       s_axil_bready;
  axil_addr_t                 s_axil_araddr;
  logic                       s_axil_arvalid;
  logic                       s_axil_arready;
  axil_data_t                 s_axil_rdata;
  logic [1:0]                 s_axil_rresp;
  logic                       s_axil_rvalid;
  logic                       s_axil_rready;
  logic [NUM_PERIPHERALS-1:0] peripheral_error;
  logic                       rslt_tlast;
  logic                       core_start;
  logic                       operation_start;
  logic                       iteration_start;
  size_t                      data_size;
  size_t                      rslt_size;
  chan_mask_t                 use_channels;
  batch_mask_t                use_batch;
  logic                       operation_busy;
  logic                       operation_complete;
  logic                       operation_error;
  logic                       locked;
  logic                       pl2ps_intr;

  int         checks;
  int         errors;
  int         start_count;
  int         core_count;
  int         iter_count;
  int         intr_count;
  chan_mask_t chan_log [0:7];
  string      test_name;

  ccu_top u_dut (.*);

  initial begin
    fsm_clk = 1'b0;
    forever #2 fsm_clk = ~fsm_clk;
  end

  // Pulse monitor, records the channel mask of every new iteration
  always @(negedge fsm_clk) begin
    if (!fsm_rst) begin
      if (operation_start) begin
        if (start_count < 8) begin
          chan_log[start_count] = use_channels;
        end
        start_count++;
      end
      if (core_start) begin
        core_count++;
      end
      if (iteration_start) begin
        iter_count++;
      end
      if (pl2ps_intr) begin
        intr_count++;
      end
    end
  end

  function automatic logic probe(input string name);
    case (name)
      "awready":            return s_axil_awready;
      "bvalid":             return s_axil_bvalid;
      "arready":            return s_axil_arready;
      "rvalid":             return s_axil_rvalid;
      "operation_start":    return operation_start;
      "operation_complete": return operation_complete;
      "operation_error":    return operation_error;
      "operation_busy":     return operation_busy;
      "locked":             return locked;
      default:              return 1'bx;
    endcase
  endfunction

  task automatic compare_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
               test_name, what, expected, actual);
      errors++;
    end
  endtask

  // Polls on falling edges until the signal reaches the level
  task automatic hold_until(input string name, input logic level);
    int n;
    n = 0;
    while (probe(name) !== level && n < TIMEOUT_CYCLES) begin
      @(negedge fsm_clk);
      n++;
    end
    checks++;
    assert (probe(name) === level) else begin
      $display("Timeout in test %s: %s did not go to %0b within %0d cycles",
               test_name, name, level, TIMEOUT_CYCLES);
      errors++;
    end
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    @(negedge fsm_clk);
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    hold_until("awready", 1'b1);
    compare_word("wready", 32'h1, s_axil_wready);
    @(negedge fsm_clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    hold_until("bvalid", 1'b1);
    // Leave the response pending for one cycle before taking it
    @(negedge fsm_clk);
    s_axil_bready = 1'b1;
    compare_word("bvalid held", 32'h1, s_axil_bvalid);
    compare_word("bresp", RESP_OKAY, s_axil_bresp);
    @(negedge fsm_clk);
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
    @(negedge fsm_clk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    hold_until("arready", 1'b1);
    @(negedge fsm_clk);
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b1;
    hold_until("rvalid", 1'b1);
    data = s_axil_rdata;
    compare_word("rresp", RESP_OKAY, s_axil_rresp);
    @(negedge fsm_clk);
    s_axil_rready = 1'b0;
  endtask

  task automatic expect_read(input axil_addr_t addr, input axil_data_t expected,
                             input string what);
    axil_data_t rd;
    axil_read(addr, rd);
    compare_word(what, expected, rd);
  endtask

  task automatic load_sizes(input size_t dsize, input size_t rsize, input btch_t bsize);
    axil_write(REG_DATA_SIZE, dsize);
    axil_write(REG_RSLT_SIZE, rsize);
    axil_write(REG_BTCH_SIZE, {24'h0, bsize});
    axil_write(REG_LOADED, 32'h3);
  endtask

  // End of one iteration after a random number of busy cycles
  task automatic send_tlast();
    int gap;
    gap = $urandom_range(1, 4);
    repeat (gap) @(negedge fsm_clk);
    rslt_tlast = 1'b1;
    @(negedge fsm_clk);
    rslt_tlast = 1'b0;
  endtask

  task automatic readback_test();
    axil_data_t dsize;
    axil_data_t rsize;
    test_name = "readback";
    dsize = $urandom;
    rsize = $urandom;
    load_sizes(dsize, rsize, 8'h3);
    expect_read(REG_DATA_SIZE, dsize, "data size");
    expect_read(REG_RSLT_SIZE, rsize, "result size");
    expect_read(REG_BTCH_SIZE, 32'h3, "batch size");
    expect_read(REG_LOADED, 32'h3, "loaded flags");
    expect_read(6'h24, 32'h0, "unmapped 0x24");
    expect_read(6'h3C, 32'h0, "unmapped 0x3C");
  endtask

  task automatic invalid_start_test();
    test_name = "invalid_start";
    // Batch count above the number of lanes
    load_sizes(32'd64, 32'd10, 8'd5);
    axil_write(REG_CTRL, 32'h1);
    hold_until("operation_error", 1'b1);
    compare_word("locked", 32'h1, locked);
    expect_read(REG_STATUS, 32'h0C, "status in error");
    axil_write(REG_CTRL, 32'h4);
    hold_until("locked", 1'b0);
    expect_read(REG_STATUS, 32'h01, "status after abort");
  endtask

  task automatic full_operation_test();
    test_name   = "full_operation";
    load_sizes(32'd64, 32'd10, 8'd3);
    start_count = 0;
    core_count  = 0;
    iter_count  = 0;
    intr_count  = 0;
    axil_write(REG_CTRL, 32'h1);
    hold_until("operation_start", 1'b1);
    compare_word("core_start", 32'h1, core_start);
    compare_word("iteration_start", 32'h1, iteration_start);
    compare_word("data_size", 32'd64, data_size);
    compare_word("rslt_size", 32'd10, rslt_size);
    compare_word("use_batch", 32'h7, use_batch);
    repeat (3) send_tlast();
    hold_until("operation_complete", 1'b1);
    compare_word("locked", 32'h1, locked);
    compare_word("operation_start count", 32'd3, start_count);
    compare_word("core_start count", 32'd1, core_count);
    compare_word("iteration_start count", 32'd3, iter_count);
    compare_word("channels, iteration 0", 32'hF, chan_log[0]);
    compare_word("channels, iteration 1", 32'hF, chan_log[1]);
    compare_word("channels, iteration 2", 32'h3, chan_log[2]);
    expect_read(REG_PROG_RSLT, 32'd10, "results exported");
    expect_read(REG_PROG_ITER, 32'd2, "iterations done");
    expect_read(REG_DONE, 32'h1, "done flag");
    compare_word("pl2ps_intr count", 32'd4, intr_count);
    axil_write(REG_DONE, 32'h0);
    hold_until("locked", 1'b0);
    compare_word("operation_busy", 32'h0, operation_busy);
  endtask

  task automatic soft_intr_test();
    test_name   = "soft_intr";
    load_sizes(32'd64, 32'd10, 8'd4);
    start_count = 0;
    axil_write(REG_CTRL, 32'h1);
    hold_until("operation_start", 1'b1);
    axil_write(REG_CTRL, 32'h2);
    // Still running until the iteration ends
    compare_word("busy before tlast", 32'h1, operation_busy);
    send_tlast();
    hold_until("operation_busy", 1'b0);
    repeat (8) @(negedge fsm_clk);
    compare_word("operation_start count", 32'd1, start_count);
    expect_read(REG_STATUS, 32'h11, "status after soft interrupt");
  endtask

  task automatic peripheral_error_test();
    test_name = "peripheral_error";
    load_sizes(32'd64, 32'd10, 8'd4);
    axil_write(REG_CTRL, 32'h1);
    hold_until("operation_start", 1'b1);
    @(negedge fsm_clk);
    peripheral_error = 2'b10;
    @(negedge fsm_clk);
    peripheral_error = '0;
    hold_until("operation_error", 1'b1);
    compare_word("locked", 32'h1, locked);
    expect_read(REG_STATUS, 32'h1C, "status in error");
    axil_write(REG_CTRL, 32'h8);
    hold_until("locked", 1'b0);
    compare_word("operation_error", 32'h0, operation_error);
    expect_read(REG_STATUS, 32'h11, "status after error interrupt");
  endtask

  initial begin
    void'($urandom(32'h6f78));
    checks           = 0;
    errors           = 0;
    start_count      = 0;
    core_count       = 0;
    iter_count       = 0;
    intr_count       = 0;
    test_name        = "reset";
    fsm_rst          = 1'b1;
    s_axil_awaddr    = '0;
    s_axil_awvalid   = 1'b0;
    s_axil_wdata     = '0;
    s_axil_wvalid    = 1'b0;
    s_axil_bready    = 1'b0;
    s_axil_araddr    = '0;
    s_axil_arvalid   = 1'b0;
    s_axil_rready    = 1'b0;
    peripheral_error = '0;
    rslt_tlast       = 1'b0;
    repeat (4) @(negedge fsm_clk);
    fsm_rst = 1'b0;

    readback_test();
    invalid_start_test();
    full_operation_test();
    soft_intr_test();
    peripheral_error_test();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== test/ccu_assertions.sv ====
module ccu_assertions
  import ccu_pkg::*;
(
  input logic       fsm_clk,
  input logic       fsm_rst,
  input ccu_state_t fsm_state,
  input logic       pl2ps_intr,
  input logic       operation_complete,
  input logic       operation_error,
  input logic       s_axil_bvalid,
  input logic       s_axil_bready
);

  timeunit 1ns;
  timeprecision 100ps;

  // Start is a single-cycle state
  assert property (@(posedge fsm_clk) disable iff (fsm_rst)
    fsm_state == ST_START |=> fsm_state != ST_START)
    else $error("FSM stayed in ST_START for more than one cycle");

  assert property (@(posedge fsm_clk) disable iff (fsm_rst)
    pl2ps_intr |=> !pl2ps_intr)
    else $error("pl2ps_intr high for two cycles in a row");

  assert property (@(posedge fsm_clk) disable iff (fsm_rst)
    !(operation_complete && operation_error))
    else $error("operation_complete and operation_error high together");

  // Write response is held until the master takes it
  assert property (@(posedge fsm_clk) disable iff (fsm_rst)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else $error("bvalid dropped before bready");

endmodule

bind ccu_top ccu_assertions u_assertions (
  .fsm_clk            (fsm_clk),
  .fsm_rst            (fsm_rst),
  .fsm_state          (u_fsm.state),
  .pl2ps_intr         (pl2ps_intr),
  .operation_complete (operation_complete),
  .operation_error    (operation_error),
  .s_axil_bvalid      (s_axil_bvalid),
  .s_axil_bready      (s_axil_bready)
);

// ==== rtl/ccu_top.sv ====
module ccu_top
  import ccu_pkg::*;
(
  input  logic                       fsm_clk,
  input  logic                       fsm_rst,

  input  axil_addr_t                 s_axil_awaddr,
  input  logic                       s_axil_awvalid,
  output logic                       s_axil_awready,
  input  axil_data_t                 s_axil_wdata,
  input  logic                       s_axil_wvalid,
  output logic                       s_axil_wready,
  output logic [1:0]                 s_axil_bresp,
  output logic                       s_axil_bvalid,
  input  logic                       s_axil_bready,
  input  axil_addr_t                 s_axil_araddr,
  input  logic                       s_axil_arvalid,
  output logic                       s_axil_arready,
  output axil_data_t                 s_axil_rdata,
  output logic [1:0]                 s_axil_rresp,
  output logic                       s_axil_rvalid,
  input  logic                       s_axil_rready,

  input  logic [NUM_PERIPHERALS-1:0] peripheral_error,
  input  logic                       rslt_tlast,

  output logic                       core_start,
  output logic                       operation_start,
  output logic                       iteration_start,
  output size_t                      data_size,
  output size_t                      rslt_size,
  output chan_mask_t                 use_channels,
  output batch_mask_t                use_batch,
  output logic                       operation_busy,
  output logic                       operation_complete,
  output logic                       operation_error,
  output logic                       locked,
  output logic                       pl2ps_intr
);

  // Register file to FSM
  size_t      data_size_reg;
  size_t      rslt_size_reg;
  btch_t      btch_size_reg;
  logic       data_loaded;
  logic       wght_loaded;
  logic       start_req;
  logic       done_flag;
  logic       soft_intr;
  logic       abort_intr;
  logic       error_intr;

  // FSM back to the register file and to the tracker
  logic       clear_start;
  logic       set_done;
  logic [4:0] status_bits;
  logic       track_clear;
  logic       track_load;
  logic       track_advance;

  // Tracker results
  logic       last_iteration;
  count_t     prog_rslt;
  count_t     prog_iter;

  ccu_axil_regs u_regs (.*);

  ccu_fsm u_fsm (.*);

  ccu_result_tracker u_tracker (.*);

endmodule

// ==== rtl/ccu_fsm.sv ====
module ccu_fsm
  import ccu_pkg::*;
(
  input  logic                       fsm_clk,
  input  logic                       fsm_rst,

  input  size_t                      data_size_reg,
  input  size_t                      rslt_size_reg,
  input  btch_t                      btch_size_reg,
  input  logic                       data_loaded,
  input  logic                       wght_loaded,
  input  logic                       start_req,
  input  logic                       done_flag,
  input  logic                       soft_intr,
  input  logic                       abort_intr,
  input  logic                       error_intr,
  input  logic [NUM_PERIPHERALS-1:0] peripheral_error,
  input  logic                       rslt_tlast,
  input  logic                       last_iteration,

  output logic                       core_start,
  output logic                       operation_start,
  output logic                       iteration_start,
  output size_t                      data_size,
  output size_t                      rslt_size,
  output logic                       operation_busy,
  output logic                       operation_complete,
  output logic                       operation_error,
  output logic                       locked,
  output logic                       pl2ps_intr,
  output logic                       clear_start,
  output logic                       set_done,
  output logic                       track_clear,
  output logic                       track_load,
  output logic                       track_advance,
  output logic [4:0]                 status_bits
);

  ccu_state_t state;
  ccu_state_t state_next;
  logic       op_valid;
  logic       soft_pend;
  logic       soft_fire;
  logic       ext_intr;
  logic       first_iter;
  logic       next_iter;
  logic       busy_next;
  logic       err_next;
  logic       end_next;

  assign op_valid = data_loaded && wght_loaded &&
                    (data_size_reg != '0) && (data_size_reg <= MAX_DATA_SIZE) &&
                    (rslt_size_reg != '0) && (rslt_size_reg <= MAX_RSLT_SIZE) &&
                    (btch_size_reg != '0) && (btch_size_reg <= BATCH_SIZE);

  // A soft interrupt only takes effect at an iteration boundary
  assign soft_fire = (soft_pend || soft_intr) &&
                     ((state == ST_OPERATE && rslt_tlast) || state == ST_ERROR);
  assign ext_intr  = abort_intr || error_intr || soft_fire;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (start_req) begin
          state_next = op_valid ? ST_START : ST_ERROR;
        end
      end
      ST_START:   state_next = ST_OPERATE;
      ST_OPERATE: begin
        if (rslt_tlast && last_iteration) begin
          state_next = ST_END;
        end
      end
      // set_done covers the cycle before the done bit is visible
      ST_END: begin
        if (!(done_flag || set_done)) begin
          state_next = ST_IDLE;
        end
      end
      ST_ERROR:   state_next = ST_ERROR;
      default:    state_next = ST_IDLE;
    endcase
    if (|peripheral_error) begin
      state_next = ST_ERROR;
    end
    if (ext_intr) begin
      state_next = ST_INTR;
    end
  end

  assign first_iter = (state == ST_START) && (state_next == ST_OPERATE);
  assign next_iter  = (state == ST_OPERATE) && rslt_tlast && (state_next == ST_OPERATE);
  assign busy_next  = (state_next == ST_START) || (state_next == ST_OPERATE);
  assign err_next   = (state_next == ST_ERROR);
  assign end_next   = (state_next == ST_END);

  assign track_clear   = (state != ST_IDLE) && (state_next == ST_IDLE);
  assign track_load    = (state == ST_IDLE) && (state_next == ST_START);
  assign track_advance = first_iter || next_iter;

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      state              <= ST_IDLE;
      soft_pend          <= 1'b0;
      core_start         <= 1'b0;
      operation_start    <= 1'b0;
      iteration_start    <= 1'b0;
      operation_busy     <= 1'b0;
      operation_complete <= 1'b0;
      operation_error    <= 1'b0;
      locked             <= 1'b0;
      pl2ps_intr         <= 1'b0;
      clear_start        <= 1'b0;
      set_done           <= 1'b0;
      status_bits        <= '0;
    end else begin
      state              <= state_next;
      core_start         <= first_iter;
      operation_start    <= first_iter || next_iter;
      iteration_start    <= first_iter || next_iter;
      operation_busy     <= busy_next;
      operation_complete <= end_next;
      operation_error    <= err_next;
      locked             <= err_next || end_next;
      pl2ps_intr         <= track_load || next_iter ||
                            (end_next && state != ST_END) ||
                            (err_next && state != ST_ERROR);
      clear_start        <= (state == ST_IDLE) && start_req;
      set_done           <= end_next && (state != ST_END);
      // valid, locked, error, busy, idle
      status_bits        <= {op_valid, err_next || end_next, err_next, busy_next,
                             ~(busy_next || err_next)};

      if (state_next == ST_IDLE || state_next == ST_INTR) begin
        soft_pend <= 1'b0;
      end else if (soft_intr) begin
        soft_pend <= 1'b1;
      end
    end
  end

  // Sizes are frozen for the whole operation
  always_ff @(posedge fsm_clk) begin
    if (track_load) begin
      data_size <= data_size_reg;
      rslt_size <= rslt_size_reg;
    end
  end

endmodule

// ==== rtl/ccu_result_tracker.sv ====
module ccu_result_tracker
  import ccu_pkg::*;
(
  input  logic        fsm_clk,
  input  logic        fsm_rst,
  input  logic        track_clear,
  input  logic        track_load,
  input  logic        track_advance,
  input  size_t       rslt_size_reg,
  input  btch_t       btch_size_reg,
  output chan_mask_t  use_channels,
  output batch_mask_t use_batch,
  output logic        last_iteration,
  output count_t      prog_rslt,
  output count_t      prog_iter
);

  count_t      rslt_left;
  count_t      step;
  logic        first_step;
  chan_mask_t  chan_next;
  batch_mask_t batch_next;

  // Results handled by the next iteration, at most one per channel
  always_comb begin
    if (rslt_left < count_t'(RSLT_CHANNELS)) begin
      step = rslt_left;
    end else begin
      step = count_t'(RSLT_CHANNELS);
    end
    for (int i = 0; i < RSLT_CHANNELS; i++) begin
      chan_next[i] = count_t'(i) < step;
    end
    for (int i = 0; i < BATCH_SIZE; i++) begin
      batch_next[i] = btch_t'(i) < btch_size_reg;
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst || track_clear) begin
      rslt_left    <= '0;
      prog_rslt    <= '0;
      prog_iter    <= '0;
      first_step   <= 1'b0;
      use_channels <= '0;
      use_batch    <= '0;
    end else if (track_load) begin
      rslt_left    <= rslt_size_reg[COUNT_W-1:0];
      prog_rslt    <= '0;
      prog_iter    <= '0;
      first_step   <= 1'b1;
      use_channels <= '0;
      use_batch    <= batch_next;
    end else if (track_advance) begin
      rslt_left    <= rslt_left - step;
      prog_rslt    <= prog_rslt + step;
      use_channels <= chan_next;
      first_step   <= 1'b0;
      // The opening iteration is not a completed one
      if (!first_step) begin
        prog_iter <= prog_iter + 1'b1;
      end
    end
  end

  assign last_iteration = (rslt_left == '0);

endmodule

// ==== rtl/ccu_axil_regs.sv ====
module ccu_axil_regs
  import ccu_pkg::*;
(
  input  logic        fsm_clk,
  input  logic        fsm_rst,

  input  axil_addr_t  s_axil_awaddr,
  input  logic        s_axil_awvalid,
  output logic        s_axil_awready,
  input  axil_data_t  s_axil_wdata,
  input  logic        s_axil_wvalid,
  output logic        s_axil_wready,
  output logic [1:0]  s_axil_bresp,
  output logic        s_axil_bvalid,
  input  logic        s_axil_bready,
  input  axil_addr_t  s_axil_araddr,
  input  logic        s_axil_arvalid,
  output logic        s_axil_arready,
  output axil_data_t  s_axil_rdata,
  output logic [1:0]  s_axil_rresp,
  output logic        s_axil_rvalid,
  input  logic        s_axil_rready,

  input  logic        clear_start,
  input  logic        set_done,
  input  logic [4:0]  status_bits,
  input  count_t      prog_rslt,
  input  count_t      prog_iter,

  output size_t       data_size_reg,
  output size_t       rslt_size_reg,
  output btch_t       btch_size_reg,
  output logic        data_loaded,
  output logic        wght_loaded,
  output logic        start_req,
  output logic        done_flag,
  output logic        soft_intr,
  output logic        abort_intr,
  output logic        error_intr
);

  logic       wr_en;
  logic       rd_en;
  axil_data_t rd_word;

  // Address and data are accepted together in one beat
  assign wr_en = s_axil_awready & s_axil_awvalid & s_axil_wvalid;
  assign rd_en = s_axil_arready & s_axil_arvalid;

  assign s_axil_wready = s_axil_awready;
  assign s_axil_bresp  = RESP_OKAY;
  assign s_axil_rresp  = RESP_OKAY;

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      s_axil_awready <= 1'b0;
      s_axil_bvalid  <= 1'b0;
      s_axil_arready <= 1'b0;
      s_axil_rvalid  <= 1'b0;
    end else begin
      s_axil_awready <= s_axil_awvalid & s_axil_wvalid & ~s_axil_awready & ~s_axil_bvalid;
      if (wr_en) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end

      s_axil_arready <= s_axil_arvalid & ~s_axil_arready & ~s_axil_rvalid;
      if (rd_en) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (rd_en) begin
      s_axil_rdata <= rd_word;
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (fsm_rst) begin
      data_size_reg <= '0;
      rslt_size_reg <= '0;
      btch_size_reg <= '0;
      data_loaded   <= 1'b0;
      wght_loaded   <= 1'b0;
      start_req     <= 1'b0;
      done_flag     <= 1'b0;
      soft_intr     <= 1'b0;
      abort_intr    <= 1'b0;
      error_intr    <= 1'b0;
    end else begin
      // Interrupt bits are write-one pulses
      soft_intr  <= 1'b0;
      abort_intr <= 1'b0;
      error_intr <= 1'b0;

      if (wr_en) begin
        case (s_axil_awaddr)
          REG_CTRL: begin
            start_req  <= s_axil_wdata[0];
            soft_intr  <= s_axil_wdata[1];
            abort_intr <= s_axil_wdata[2];
            error_intr <= s_axil_wdata[3];
          end
          REG_DONE:      done_flag     <= s_axil_wdata[0];
          REG_DATA_SIZE: data_size_reg <= s_axil_wdata;
          REG_RSLT_SIZE: rslt_size_reg <= s_axil_wdata;
          REG_BTCH_SIZE: btch_size_reg <= s_axil_wdata[7:0];
          REG_LOADED: begin
            data_loaded <= s_axil_wdata[0];
            wght_loaded <= s_axil_wdata[1];
          end
          default: begin
          end
        endcase
      end

      // FSM requests override a software write in the same cycle
      if (clear_start) begin
        start_req <= 1'b0;
      end
      if (set_done) begin
        done_flag <= 1'b1;
      end
    end
  end

  always_comb begin
    rd_word = '0;
    case (s_axil_araddr)
      REG_CTRL:      rd_word[0]            = start_req;
      REG_DONE:      rd_word[0]            = done_flag;
      REG_DATA_SIZE: rd_word               = data_size_reg;
      REG_RSLT_SIZE: rd_word               = rslt_size_reg;
      REG_BTCH_SIZE: rd_word[7:0]          = btch_size_reg;
      REG_LOADED:    rd_word[1:0]          = {wght_loaded, data_loaded};
      REG_STATUS:    rd_word[4:0]          = status_bits;
      REG_PROG_RSLT: rd_word[COUNT_W-1:0]  = prog_rslt;
      REG_PROG_ITER: rd_word[COUNT_W-1:0]  = prog_iter;
      default: begin
      end
    endcase
  end

endmodule

// ==== rtl/ccu_pkg.sv ====
package ccu_pkg;

  // Bus and datapath widths
  localparam int CTLR_ADDR = 6;
  localparam int AXIL_DATA = 32;
  localparam int COUNT_W   = 24;

  // Array geometry
  localparam int RSLT_CHANNELS   = 4;
  localparam int BATCH_SIZE      = 4;
  localparam int NUM_PERIPHERALS = 2;

  // Largest sizes accepted by the validity check
  localparam int MAX_DATA_SIZE = 65536;
  localparam int MAX_RSLT_SIZE = 65536;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef logic [CTLR_ADDR-1:0]     axil_addr_t;
  typedef logic [AXIL_DATA-1:0]     axil_data_t;
  typedef logic [31:0]              size_t;
  typedef logic [COUNT_W-1:0]       count_t;
  typedef logic [7:0]               btch_t;
  typedef logic [RSLT_CHANNELS-1:0] chan_mask_t;
  typedef logic [BATCH_SIZE-1:0]    batch_mask_t;

  // Register map, byte addresses
  localparam axil_addr_t REG_CTRL      = 6'h00;
  localparam axil_addr_t REG_DONE      = 6'h04;
  localparam axil_addr_t REG_DATA_SIZE = 6'h08;
  localparam axil_addr_t REG_RSLT_SIZE = 6'h0C;
  localparam axil_addr_t REG_BTCH_SIZE = 6'h10;
  localparam axil_addr_t REG_LOADED    = 6'h14;
  // Read-only from here on
  localparam axil_addr_t REG_STATUS    = 6'h18;
  localparam axil_addr_t REG_PROG_RSLT = 6'h1C;
  localparam axil_addr_t REG_PROG_ITER = 6'h20;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_OPERATE,
    ST_END,
    ST_ERROR,
    ST_INTR
  } ccu_state_t;

endpackage
